// ==== Makefile ====
# Verilator build of the sine accelerator testbench

VERILATOR ?= verilator
TOP ?= sineAccelTb
FILELIST ?= sources.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal -j 0
FAIL_MSG ?= Regression failed

SIM = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@./$(SIM) > $(LOG) 2>&1; rc=$$?; cat $(LOG); exit $$rc
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	else \
		echo "Simulation finished without failures"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== boothsDiv.sv ====
`timescale 1ns/10ps

module boothsDiv #(
	parameter int width = 16
) (
	input  logic signed [width-1:0] n,
	input  logic signed [width-1:0] d,
	output logic signed [width-1:0] q,
	output logic signed [width-1:0] r
);
	logic [width-1:0] nMag;
	logic [width-1:0] dMag;
	logic [width-1:0] qMag;
	logic [width-1:0] rMag;
	// Partial remainder and trial difference, one bit wider than the operands
	logic [width:0] acc;
	logic [width:0] diff;

	// Most negative value still maps to its correct unsigned magnitude
	assign nMag = n[width-1] ? -n : n;
	assign dMag = d[width-1] ? -d : d;

	//////////////////////////////////////////////////
	// Unrolled restoring division, MSB first
	//////////////////////////////////////////////////

	always_comb begin
		acc = '0;
		diff = '0;
		qMag = '0;
		for (int i = width - 1; i >= 0; i--) begin
			acc = {acc[width-1:0], nMag[i]};
			diff = acc - {1'b0, dMag};
			if (diff[width]) begin
				// Negative trial, keep the old remainder
				qMag[i] = 1'b0;
			end else begin
				acc = diff;
				qMag[i] = 1'b1;
			end
		end
		rMag = acc[width-1:0];
	end

	// Quotient sign from both operands, remainder follows the dividend
	assign q = (n[width-1] ^ d[width-1]) ? -qMag : qMag;
	assign r = n[width-1] ? -rMag : rMag;

endmodule

// ==== boothsMult.sv ====
`timescale 1ns/10ps

module boothsMult #(
	parameter int aWidth = 8,
	parameter int bWidth = 8
) (
	input  logic signed [aWidth-1:0] a,
	input  logic signed [bWidth-1:0] b,
	output logic signed [aWidth+bWidth-1:0] p
);
	localparam int prodW = aWidth + bWidth;

	logic signed [prodW-1:0] aExt;
	// Multiplier with the implicit zero below bit 0
	logic [bWidth:0] bPad;

	assign aExt = {{bWidth{a[aWidth-1]}}, a};
	assign bPad = {b, 1'b0};

	// Radix-2 recoding, one bit pair per partial product
	always_comb begin
		p = '0;
		for (int i = 0; i < bWidth; i++) begin
			case (bPad[i +: 2])
				2'b01: p = p + (aExt <<< i);
				2'b10: p = p - (aExt <<< i);
				default: ;
			endcase
		end
	end

endmodule

// ==== laneDispatcher.sv ====
`timescale 1ns/10ps

module laneDispatcher #(
	parameter int numLanes = 4
) (
	input  logic clk,
	input  logic arstN,
	input  logic signed [trigPkg::ANGLE_W-1:0] angle,
	input  logic reqValid,
	output logic reqReady,
	output trigPkg::sineReq_t laneReq,
	output logic [numLanes-1:0] laneReqValid,
	input  logic [numLanes-1:0] laneReqReady,
	output logic issued
);
	import trigPkg::*;

	localparam int ptrW = (numLanes > 1) ? $clog2(numLanes) : 1;

	logic [ptrW-1:0] ptr;
	logic [TAG_W-1:0] tag;

	// Request goes to every lane, only the selected one sees valid
	assign laneReq.tag = tag;
	assign laneReq.angle = angle;

	always_comb begin
		laneReqValid = '0;
		laneReqValid[ptr] = reqValid;
	end

	assign reqReady = laneReqReady[ptr];
	assign issued = reqValid && reqReady;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			ptr <= '0;
			tag <= '0;
		end else if (issued) begin
			ptr <= (ptr == ptrW'(numLanes - 1)) ? '0 : ptr + 1'b1;
			// Tag wraps naturally at 256
			tag <= tag + 1'b1;
		end
	end

endmodule

// ==== resultCollector.sv ====
`timescale 1ns/10ps

module resultCollector #(
	parameter int numLanes = 4,
	parameter int fifoDepth = 8
) (
	input  logic clk,
	input  logic arstN,
	input  trigPkg::sineRes_t laneRes [numLanes],
	input  logic [numLanes-1:0] laneResValid,
	output logic [numLanes-1:0] laneResTake,
	output trigPkg::sineRes_t head,
	output logic headValid,
	input  logic pop,
	output logic [7:0] level,
	output logic drained
);
	import trigPkg::*;

	localparam int ptrW = (numLanes > 1) ? $clog2(numLanes) : 1;
	localparam int addrW = (fifoDepth > 1) ? $clog2(fifoDepth) : 1;
	localparam int cntW = $clog2(fifoDepth + 1);

	sineRes_t mem [fifoDepth];
	logic [ptrW-1:0] lanePtr;
	logic [addrW-1:0] wrPtr;
	logic [addrW-1:0] rdPtr;
	logic [cntW-1:0] count;
	logic full;
	logic popEn;

	assign full = (count == cntW'(fifoDepth));
	assign headValid = (count != '0);
	assign head = mem[rdPtr];
	assign level = 8'(count);
	assign popEn = pop && headValid;

	// Only the lane whose turn it is may hand over a result
	assign drained = laneResValid[lanePtr] && !full;

	always_comb begin
		laneResTake = '0;
		laneResTake[lanePtr] = drained;
	end

	//////////////////////////////////////////////////
	// Pointers and level
	//////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			lanePtr <= '0;
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (drained) begin
				lanePtr <= (lanePtr == ptrW'(numLanes - 1)) ? '0 : lanePtr + 1'b1;
				wrPtr <= (wrPtr == addrW'(fifoDepth - 1)) ? '0 : wrPtr + 1'b1;
			end
			if (popEn)
				rdPtr <= (rdPtr == addrW'(fifoDepth - 1)) ? '0 : rdPtr + 1'b1;
			if (drained && !popEn)
				count <= count + 1'b1;
			else if (popEn && !drained)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (drained)
			mem[wrPtr] <= laneRes[lanePtr];
	end

endmodule

// ==== sine.sv ====
`timescale 1ns/10ps

module sine #(
	parameter int intBits = 2,
	parameter int decimalBits = 8
) (
	input  logic signed [intBits+decimalBits:0] x,
	output logic signed [decimalBits+1:0] y
);
	// One extra bit so |x| of the most negative angle stays positive
	localparam int redW = intBits + decimalBits + 2;
	// Powers up to (pi/2)^7 reach about 23.5, five integer bits plus sign
	localparam int powW = decimalBits + 6;
	localparam int modW = decimalBits + 2;

	localparam logic signed [redW-1:0] piHalf =
		redW'(int'(3.14159265358979 * (2.0 ** (decimalBits - 1))));
	localparam logic signed [powW-1:0] fact3 = powW'(6);

	logic signed [redW-1:0] xExt;
	logic signed [redW-1:0] absX;
	logic signed [redW-1:0] quad;
	logic signed [redW-1:0] rem;
	logic signed [modW-1:0] modX;
	logic signed [powW-1:0] modXW;
	logic signed [2*powW-1:0] x2Full;
	logic signed [2*powW-1:0] x3Full;
	logic signed [powW-1:0] x2;
	logic signed [powW-1:0] x3;
	logic signed [powW-1:0] t3;
	logic signed [powW-1:0] poly1;
	logic signed [powW-1:0] poly;
	logic signed [modW-1:0] sumMag;
	logic negate;

	//////////////////////////////////////////////////
	// Reduction modulo pi/2
	//////////////////////////////////////////////////

	assign xExt = {x[intBits+decimalBits], x};
	assign absX = xExt[redW-1] ? -xExt : xExt;

	boothsDiv #(.width(redW)) modCalc (.n(absX), .d(piHalf), .q(quad), .r(rem));

	// Odd quadrant, mirror back from pi/2
	assign modX = quad[0] ? modW'(piHalf - rem) : modW'(rem);
	assign modXW = powW'(modX);

	//////////////////////////////////////////////////
	// Taylor polynomial
	//////////////////////////////////////////////////

	boothsMult #(.aWidth(powW), .bWidth(powW)) x2Calc (.a(modXW), .b(modXW), .p(x2Full));
	assign x2 = x2Full[decimalBits +: powW];

	boothsMult #(.aWidth(powW), .bWidth(powW)) x3Calc (.a(x2), .b(modXW), .p(x3Full));
	assign x3 = x3Full[decimalBits +: powW];

	boothsDiv #(.width(powW)) div3Calc (.n(x3), .d(fact3), .q(t3), .r());

	assign poly1 = modXW - t3;

	// Terms are only worth adding while they reach the LSB
	generate
		if (decimalBits > 3) begin : gTerm5
			localparam logic signed [powW-1:0] fact5 = powW'(120);
			logic signed [2*powW-1:0] x5Full;
			logic signed [powW-1:0] x5;
			logic signed [powW-1:0] t5;
			logic signed [powW-1:0] poly2;

			boothsMult #(.aWidth(powW), .bWidth(powW)) x5Calc (.a(x3), .b(x2), .p(x5Full));
			assign x5 = x5Full[decimalBits +: powW];
			boothsDiv #(.width(powW)) div5Calc (.n(x5), .d(fact5), .q(t5), .r());
			assign poly2 = poly1 + t5;

			if (decimalBits > 7) begin : gTerm7
				localparam logic signed [powW-1:0] fact7 = powW'(5040);
				logic signed [2*powW-1:0] x7Full;
				logic signed [powW-1:0] x7;
				logic signed [powW-1:0] t7;

				boothsMult #(.aWidth(powW), .bWidth(powW)) x7Calc (.a(x5), .b(x2), .p(x7Full));
				assign x7 = x7Full[decimalBits +: powW];
				boothsDiv #(.width(powW)) div7Calc (.n(x7), .d(fact7), .q(t7), .r());
				assign poly = poly2 - t7;
			end else begin : gSum5
				assign poly = poly2;
			end
		end else begin : gSum3
			assign poly = poly1;
		end
	endgenerate

	// Third and fourth quadrant, or a negative input, flip the sign
	assign negate = quad[1] ^ x[intBits+decimalBits];
	assign sumMag = poly[modW-1:0];
	assign y = negate ? -sumMag : sumMag;

endmodule

// ==== sineAccel.sv ====
`timescale 1ns/10ps

module sineAccel #(
	parameter int numLanes = 4,
	parameter int fifoDepth = 8
) (
	input  logic clk,
	input  logic arstN,
	input  logic cyc,
	input  logic stb,
	input  logic we,
	input  logic [1:0] adr,
	input  logic [31:0] datW,
	output logic [31:0] datR,
	output logic ack
);
	import trigPkg::*;

	logic signed [ANGLE_W-1:0] angle;
	logic reqValid;
	logic reqReady;
	logic issued;
	sineReq_t laneReq;
	logic [numLanes-1:0] laneReqValid;
	logic [numLanes-1:0] laneReqReady;
	sineRes_t laneRes [numLanes];
	logic [numLanes-1:0] laneResValid;
	logic [numLanes-1:0] laneResTake;
	sineRes_t head;
	logic headValid;
	logic pop;
	logic [7:0] level;
	logic drained;

	wbSineRegs u_regs (
		.clk(clk), .arstN(arstN), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
		.datW(datW), .datR(datR), .ack(ack),
		.angle(angle), .reqValid(reqValid), .reqReady(reqReady),
		.head(head), .headValid(headValid), .pop(pop), .level(level),
		.issued(issued), .drained(drained)
	);

	laneDispatcher #(.numLanes(numLanes)) u_dispatch (
		.clk(clk), .arstN(arstN), .angle(angle), .reqValid(reqValid),
		.reqReady(reqReady), .laneReq(laneReq), .laneReqValid(laneReqValid),
		.laneReqReady(laneReqReady), .issued(issued)
	);

	//////////////////////////////////////////////////
	// Sine lanes
	//////////////////////////////////////////////////

	for (genvar i = 0; i < numLanes; i++) begin : gLane
		sineLane #(.intBits(INT_BITS), .decimalBits(DEC_BITS)) u_lane (
			.clk(clk), .arstN(arstN), .req(laneReq), .reqValid(laneReqValid[i]),
			.reqReady(laneReqReady[i]), .res(laneRes[i]), .resValid(laneResValid[i]),
			.take(laneResTake[i])
		);
	end

	resultCollector #(.numLanes(numLanes), .fifoDepth(fifoDepth)) u_collect (
		.clk(clk), .arstN(arstN), .laneRes(laneRes), .laneResValid(laneResValid),
		.laneResTake(laneResTake), .head(head), .headValid(headValid), .pop(pop),
		.level(level), .drained(drained)
	);

endmodule

// ==== sineAccelTb.sv ====
`timescale 1ns/10ps

module sineAccelTb;
	import trigPkg::*;

	localparam int numLanes = 4;
	localparam int fifoDepth = 8;
	// Bus cycles allowed for one ack
	localparam int ackLimit = 200;
	// Register reads allowed while polling
	localparam int pollLimit = 100;
	// Cycles a blocked write is held before it is abandoned
	localparam int blockCycles = 60;
	localparam real tolerance = 4.0;

	logic clk = 1'b0;
	logic arstN;
	logic cyc;
	logic stb;
	logic we;
	logic [1:0] adr;
	logic [31:0] datW;
	logic [31:0] datR;
	logic ack;

	int valueErrors;
	int timeouts;
	// Angles and tags in issue order, still to be read back
	int expAngle[$];
	logic [TAG_W-1:0] expTag[$];
	logic [TAG_W-1:0] nextTag;

	sineAccel #(.numLanes(numLanes), .fifoDepth(fifoDepth)) u_dut (
		.clk(clk), .arstN(arstN), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
		.datW(datW), .datR(datR), .ack(ack)
	);

	always #20 clk = ~clk;

	//////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////

	// Ideal sine, scaled to result LSBs
	function automatic real refSine(input int a);
		return $sin(real'(a) / (2.0 ** DEC_BITS)) * (2.0 ** DEC_BITS);
	endfunction

	function automatic int resultValue(input logic [31:0] word);
		return int'($signed(word[9:0]));
	endfunction

	function automatic int randomAngle();
		return int'($urandom_range(2047, 0)) - 1024;
	endfunction

	//////////////////////////////////////////////////
	// Wishbone master
	//////////////////////////////////////////////////

	// One classic cycle, abandoned if no ack within maxCycles
	task automatic busAccess(input logic wrEn, input logic [1:0] addr, input logic [31:0] data,
		input int maxCycles, output logic [31:0] rdData, output bit acked);
		int n;
		@(negedge clk);
		cyc = 1'b1;
		stb = 1'b1;
		we = wrEn;
		adr = addr;
		datW = data;
		acked = 1'b0;
		n = 0;
		while (!acked && n < maxCycles) begin
			@(negedge clk);
			n++;
			if (ack)
				acked = 1'b1;
		end
		rdData = datR;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
	endtask

	task automatic issueAngle(input int a, input int maxCycles, output bit acked);
		logic [31:0] rdData;
		busAccess(1'b1, ADDR_ANGLE, 32'(a), maxCycles, rdData, acked);
		if (acked) begin
			expAngle.push_back(a);
			expTag.push_back(nextTag);
			nextTag++;
		end
	endtask

	task automatic writeAngle(input int a);
		bit acked;
		issueAngle(a, ackLimit, acked);
		if (!acked) begin
			timeouts++;
			$display("Timeout: the write of angle %0d was never acknowledged", a);
		end
	endtask

	task automatic readReg(input logic [1:0] addr, output logic [31:0] data);
		bit acked;
		busAccess(1'b0, addr, 32'h0, ackLimit, data, acked);
		if (!acked) begin
			timeouts++;
			$display("Timeout: the read of address %0d was never acknowledged", addr);
		end
	endtask

	// Polls the result register until its valid flag is set
	task automatic fetchResult(output logic [31:0] word);
		int n;
		n = 0;
		word = '0;
		while (!word[31] && n < pollLimit) begin
			readReg(ADDR_RESULT, word);
			n++;
		end
		if (!word[31]) begin
			timeouts++;
			$display("Timeout: no valid result after %0d reads", pollLimit);
		end
	endtask

	// Reads one result and compares it with the oldest outstanding angle
	task automatic collectOne(output int v);
		logic [31:0] word;
		int a;
		logic [TAG_W-1:0] t;
		real err;
		fetchResult(word);
		v = resultValue(word);
		assert (expAngle.size() > 0) else begin
			valueErrors++;
			$display("ERR %0t: result with tag %0d but nothing outstanding", $time, word[23:16]);
		end
		if (expAngle.size() > 0) begin
			a = expAngle.pop_front();
			t = expTag.pop_front();
			err = real'(v) - refSine(a);
			if (err < 0.0)
				err = -err;
			assert (word[23:16] == t) else begin
				valueErrors++;
				$display("ERR %0t: tag %0d, expected %0d", $time, word[23:16], t);
			end
			assert (err <= tolerance) else begin
				valueErrors++;
				$display("ERR %0t: angle %0d gave %0d, expected %f", $time, a, v, refSine(a));
			end
		end
	endtask

	// Waits until nothing is in flight and the FIFO holds expLevel results
	task automatic waitIdle(input int expLevel);
		logic [31:0] s;
		int n;
		n = 0;
		readReg(ADDR_STATUS, s);
		while ((s[15:8] != 8'd0 || int'(s[7:0]) != expLevel) && n < pollLimit) begin
			readReg(ADDR_STATUS, s);
			n++;
		end
		if (s[15:8] != 8'd0 || int'(s[7:0]) != expLevel) begin
			timeouts++;
			$display("Timeout: status stuck at level %0d with %0d in flight, wanted level %0d",
				s[7:0], s[15:8], expLevel);
		end
	endtask

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////

	initial begin
		logic [31:0] word;
		int a;
		int v1;
		int v2;
		bit acked;
		arstN = 1'b0;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = 2'd0;
		datW = 32'h0;
		valueErrors = 0;
		timeouts = 0;
		nextTag = '0;
		void'($urandom(30));

		repeat (10) @(negedge clk);
		arstN = 1'b1;
		repeat (2) @(negedge clk);

		// Empty after reset
		readReg(ADDR_STATUS, word);
		assert (word[15:0] == 16'h0) else begin
			valueErrors++;
			$display("ERR %0t: status after reset is %h", $time, word);
		end
		readReg(ADDR_RESULT, word);
		assert (!word[31]) else begin
			valueErrors++;
			$display("ERR %0t: result valid right after reset", $time);
		end

		// One angle at a time
		for (int i = 0; i < 200; i++) begin
			writeAngle(randomAngle());
			collectOne(v1);
		end

		// Odd symmetry
		for (int i = 0; i < 20; i++) begin
			a = int'($urandom_range(1023, 1));
			writeAngle(a);
			collectOne(v1);
			writeAngle(-a);
			collectOne(v2);
			assert (v2 == -v1) else begin
				valueErrors++;
				$display("ERR %0t: sin(%0d) = %0d but sin(%0d) = %0d", $time, a, v1, -a, v2);
			end
		end

		// Burst that spans every lane, read back once drained
		for (int i = 0; i < fifoDepth; i++)
			writeAngle(randomAngle());
		waitIdle(fifoDepth);
		for (int i = 0; i < fifoDepth; i++)
			collectOne(v1);

		// Fill the FIFO and both stages of every lane
		for (int i = 0; i < fifoDepth + 2 * numLanes; i++)
			writeAngle(randomAngle());
		a = randomAngle();
		issueAngle(a, blockCycles, acked);
		assert (!acked) else begin
			valueErrors++;
			$display("ERR %0t: write acknowledged while every lane was full", $time);
		end
		// One read frees a slot, so the write goes through
		collectOne(v1);
		if (!acked)
			writeAngle(a);
		for (int i = 0; i < fifoDepth + 2 * numLanes; i++)
			collectOne(v1);
		waitIdle(0);
		// Nothing left once every result has been read
		readReg(ADDR_RESULT, word);
		assert (!word[31]) else begin
			valueErrors++;
			$display("ERR %0t: stray result with tag %0d", $time, word[23:16]);
		end

		$display("Error counts: %0d value errors, %0d timeouts", valueErrors, timeouts);
		if (valueErrors == 0 && timeouts == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

// ==== sineLane.sv ====
`timescale 1ns/10ps

module sineLane #(
	parameter int intBits = 2,
	parameter int decimalBits = 8
) (
	input  logic clk,
	input  logic arstN,
	input  trigPkg::sineReq_t req,
	input  logic reqValid,
	output logic reqReady,
	output trigPkg::sineRes_t res,
	output logic resValid,
	input  logic take
);
	import trigPkg::*;

	sineReq_t s1Req;
	logic s1Valid;
	logic s2Free;
	logic signed [SINE_W-1:0] sineY;

	sine #(.intBits(intBits), .decimalBits(decimalBits)) u_sine (.x(s1Req.angle), .y(sineY));

	// Output stage is free when empty or being taken this cycle
	assign s2Free = !resValid || take;
	assign reqReady = !s1Valid || s2Free;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			s1Valid <= 1'b0;
			resValid <= 1'b0;
		end else begin
			if (reqReady)
				s1Valid <= reqValid;
			if (s2Free)
				resValid <= s1Valid;
		end
	end

	always_ff @(posedge clk) begin
		if (reqReady && reqValid)
			s1Req <= req;
		if (s2Free && s1Valid) begin
			res.tag <= s1Req.tag;
			res.value <= sineY;
		end
	end

endmodule

// ==== sources.f ====
trigPkg.sv
boothsMult.sv
boothsDiv.sv
sine.sv
sineLane.sv
laneDispatcher.sv
resultCollector.sv
wbSineRegs.sv
sineAccel.sv
sineAccelTb.sv

// ==== trigPkg.sv ====
package trigPkg;

	//////////////////////////////////////////////////
	// Number format
	//////////////////////////////////////////////////

	// Angle is Q2.8 plus sign
	localparam int INT_BITS = 2;
	localparam int DEC_BITS = 8;
	localparam int ANGLE_W = INT_BITS + DEC_BITS + 1;
	// Result is Q1.8 plus sign
	localparam int SINE_W = DEC_BITS + 2;
	localparam int TAG_W = 8;

	//////////////////////////////////////////////////
	// Register map, word addresses
	//////////////////////////////////////////////////

	localparam logic [1:0] ADDR_ANGLE = 2'd0;
	localparam logic [1:0] ADDR_RESULT = 2'd1;
	localparam logic [1:0] ADDR_STATUS = 2'd2;

	// Dispatcher to lane
	typedef struct packed {
		logic [TAG_W-1:0] tag;
		logic signed [ANGLE_W-1:0] angle;
	} sineReq_t;

	// Lane to collector and through the FIFO
	typedef struct packed {
		logic [TAG_W-1:0] tag;
		logic signed [SINE_W-1:0] value;
	} sineRes_t;

endpackage

// ==== wbSineRegs.sv ====
`timescale 1ns/10ps

module wbSineRegs (
	input  logic clk,
	input  logic arstN,
	input  logic cyc,
	input  logic stb,
	input  logic we,
	input  logic [1:0] adr,
	input  logic [31:0] datW,
	output logic [31:0] datR,
	output logic ack,
	output logic signed [trigPkg::ANGLE_W-1:0] angle,
	output logic reqValid,
	input  logic reqReady,
	input  trigPkg::sineRes_t head,
	input  logic headValid,
	output logic pop,
	input  logic [7:0] level,
	input  logic issued,
	input  logic drained
);
	import trigPkg::*;

	logic active;
	logic [7:0] inFlight;

	// Masked during the ack cycle so one access is never taken twice
	assign active = cyc && stb && !ack;
	assign reqValid = active && we && (adr == ADDR_ANGLE);
	assign angle = datW[ANGLE_W-1:0];
	assign pop = active && !we && (adr == ADDR_RESULT) && headValid;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			ack <= 1'b0;
			inFlight <= '0;
		end else begin
			// Angle write waits for a free lane
			ack <= active && (!reqValid || reqReady);
			if (issued && !drained)
				inFlight <= inFlight + 1'b1;
			else if (drained && !issued)
				inFlight <= inFlight - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (active && !we) begin
			case (adr)
				ADDR_RESULT:
					datR <= headValid ?
						{1'b1, 7'b0, head.tag, {(16 - SINE_W){1'b0}}, head.value} : '0;
				ADDR_STATUS: datR <= {16'b0, inFlight, level};
				default: datR <= '0;
			endcase
		end
	end

endmodule
